// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= wb_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
verilog/wb_pkg.sv
verilog/inst_latch.sv
verilog/lsu_mem.sv
verilog/wb_ctrl.sv
verilog/arch_state.sv
verilog/wb_subsys_top.sv
tests/wb_tb.sv

// File: tests/wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_tb;

    import wb_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int NUM_ALU        = 12;
    localparam int NUM_MEM        = 4;

    logic                  clk;
    logic                  rst;
    logic                  ifu_valid;
    inst_rec_t             inst;
    logic                  ready;
    logic                  finish;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_LEN-1:0]   rd_data;
    logic [DATA_LEN-1:0]   csr;

    logic [31:0]         lfsr_q;
    logic [DATA_LEN-1:0] exp_regs [NUM_REGS];   // reference architectural state
    logic [DATA_LEN-1:0] exp_csr;
    logic [DATA_LEN-1:0] exp_mem [MEM_DEPTH];

    wb_subsys_top dut (
        .clk         (clk),
        .rst         (rst),
        .ifu_valid_i (ifu_valid),
        .inst_i      (inst),
        .ready_o     (ready),
        .finish_o    (finish),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .csr_o       (csr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[30:0], lfsr_q[0]};   // one step per bit
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    endtask

    // random non-memory record with all enables clear
    task automatic rand_rec(output inst_rec_t r);
        logic [31:0] val;
        r = '0;
        rand_bits(REG_ADDR_W, val);
        r.wreg = val[REG_ADDR_W-1:0];
        rand_bits(MEM_ADDR_W, val);
        r.mem_addr = val[MEM_ADDR_W-1:0];
        rand_bits(DATA_LEN, val);
        r.reg_wdata = val;
        rand_bits(DATA_LEN, val);
        r.csr_wdata = val;
    endtask

    // expected effect of one accepted instruction
    task automatic model_commit(input inst_rec_t r);
        logic [DATA_LEN-1:0] wdata;
        if (r.is_mem && r.is_store) begin
            exp_mem[r.mem_addr] = r.reg_wdata;
        end
        wdata = r.is_mem ? exp_mem[r.mem_addr] : r.reg_wdata;
        if (r.wd && (r.wreg != '0)) begin
            exp_regs[r.wreg] = wdata;
        end
        if (r.csr_we) begin
            exp_csr = r.csr_wdata;
        end
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr,
                            output logic [DATA_LEN-1:0] data);
        @(negedge clk);
        rd_addr = addr;
        #(CLK_PERIOD / 4);   // mid low phase
        data = rd_data;
    endtask

    task automatic check_state(input string name);
        logic [DATA_LEN-1:0] val;
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(REG_ADDR_W'(i), val);
            check(name, exp_regs[i], val);
        end
        check(name, exp_csr, csr);
    endtask

    // issue r and poll until ready, with an optional strobe one cycle later
    task automatic run_inst(input inst_rec_t r, input logic with_extra,
                            input inst_rec_t extra, output int fin_cyc,
                            output int fin_cnt, output int rdy_cyc);
        int  cyc;
        logic done;
        cyc     = 0;
        fin_cyc = 0;
        fin_cnt = 0;
        rdy_cyc = 0;
        done    = 1'b0;
        @(negedge clk);
        check("ready at issue", 32'd1, 32'(ready));
        ifu_valid = 1'b1;
        inst      = r;
        while (!done) begin
            @(negedge clk);
            cyc++;
            ifu_valid = 1'b0;
            if (with_extra && (cyc == 1)) begin
                ifu_valid = 1'b1;   // lands while busy
                inst      = extra;
            end
            if (finish) begin
                fin_cnt++;
                if (fin_cyc == 0) begin
                    fin_cyc = cyc;
                end
            end
            if (ready) begin
                rdy_cyc = cyc;
                done    = 1'b1;
            end else if (cyc >= TIMEOUT_CYCLES) begin
                timeout_fail("ready_o after issue");
            end
        end
        model_commit(r);
    endtask

    task automatic issue_and_check(input string name, input inst_rec_t r);
        int fin_cyc;
        int fin_cnt;
        int rdy_cyc;
        int lat;
        lat = r.is_mem ? LSU_LATENCY : 0;
        run_inst(r, 1'b0, '0, fin_cyc, fin_cnt, rdy_cyc);
        check(name, 32'(2 + lat), 32'(fin_cyc));   // finish after the commit edge
        check(name, 32'd1, 32'(fin_cnt));
        check(name, 32'(3 + lat), 32'(rdy_cyc));
    endtask

    task automatic test_reset();
        check("reset ready", 32'd1, 32'(ready));
        check("reset finish", 32'd0, 32'(finish));
        check_state("reset state");
    endtask

    task automatic test_alu_writeback();
        inst_rec_t           r;
        logic [DATA_LEN-1:0] val;
        for (int n = 0; n < NUM_ALU; n++) begin
            rand_rec(r);
            r.wd = 1'b1;
            issue_and_check("alu writeback", r);
            read_reg(r.wreg, val);
            check("alu writeback", exp_regs[r.wreg], val);
        end
        rand_rec(r);
        r.wd   = 1'b1;
        r.wreg = '0;
        issue_and_check("x0 write", r);
        read_reg('0, val);
        check("x0 write", 32'd0, val);
    endtask

    task automatic test_csr_write();
        inst_rec_t r;
        rand_rec(r);
        r.csr_we = 1'b1;   // wd stays clear
        issue_and_check("csr write", r);
        check("csr write", r.csr_wdata, csr);
        check_state("csr write");
    endtask

    task automatic test_store_load();
        inst_rec_t           st;
        inst_rec_t           ld;
        logic [DATA_LEN-1:0] val;
        for (int n = 0; n < NUM_MEM; n++) begin
            rand_rec(st);
            st.is_mem   = 1'b1;
            st.is_store = 1'b1;
            issue_and_check("store", st);
            rand_rec(ld);
            ld.wd       = 1'b1;
            ld.is_mem   = 1'b1;
            ld.mem_addr = st.mem_addr;
            if (ld.wreg == '0) begin
                ld.wreg = 5'd1;
            end
            issue_and_check("load", ld);
            read_reg(ld.wreg, val);
            check("load data", st.reg_wdata, val);
        end
        check_state("store load");
    endtask

    task automatic test_ignored_issue();
        inst_rec_t r;
        inst_rec_t extra;
        int        fin_cyc;
        int        fin_cnt;
        int        rdy_cyc;
        rand_rec(r);
        r.wd     = 1'b1;
        r.is_mem = 1'b1;   // load keeps the latched record in use through the memory wait
        rand_rec(extra);
        extra.wd     = 1'b1;
        extra.csr_we = 1'b1;
        extra.wreg   = r.wreg + 5'd1;
        run_inst(r, 1'b1, extra, fin_cyc, fin_cnt, rdy_cyc);
        check("ignored issue", 32'(2 + LSU_LATENCY), 32'(fin_cyc));
        check("ignored issue", 32'd1, 32'(fin_cnt));
        check("ignored issue", 32'(3 + LSU_LATENCY), 32'(rdy_cyc));
        repeat (4) begin
            @(negedge clk);
            check("ignored issue idle", 32'd0, 32'(finish));
            check("ignored issue idle", 32'd1, 32'(ready));
        end
        check_state("ignored issue");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        ifu_valid = 1'b0;
        inst      = '0;
        rd_addr   = '0;
        lfsr_q    = 32'h808d;
        exp_csr   = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            exp_regs[i] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            exp_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_alu_writeback();
        test_csr_write();
        test_store_load();
        test_ignored_issue();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/arch_state.sv
`timescale 1ns/1ps
`default_nettype none

module arch_state (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire wb_pkg::wb_rec_t               commit_i,
    input  wire logic [wb_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic [wb_pkg::DATA_LEN-1:0]        rd_data_o,
    output logic [wb_pkg::DATA_LEN-1:0]        csr_o
);

    import wb_pkg::*;

    logic [DATA_LEN-1:0] regs [NUM_REGS];
    logic [DATA_LEN-1:0] scratch;

    // general purpose registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i.wd && (commit_i.wreg != '0)) begin
            regs[commit_i.wreg] <= commit_i.wdata;   // x0 never written
        end
    end

    // scratch csr
    always_ff @(posedge clk) begin
        if (rst) begin
            scratch <= '0;
        end else if (commit_i.csr_we) begin
            scratch <= commit_i.csr_wdata;
        end
    end

    assign rd_data_o = regs[rd_addr_i];
    assign csr_o     = scratch;

endmodule

`default_nettype wire

// File: verilog/inst_latch.sv
`timescale 1ns/1ps
`default_nettype none

// holds the issued instruction while writeback runs
module inst_latch (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              load_i,
    input  wire wb_pkg::inst_rec_t inst_i,
    output wb_pkg::inst_rec_t      rec_o
);

    wb_pkg::inst_rec_t rec_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_q <= '0;
        end else if (load_i) begin
            rec_q <= inst_i;   // only on accepted issue
        end
    end

    // stays put until the next accept, so later stages see a stable record
    assign rec_o = rec_q;

endmodule

`default_nettype wire

// File: verilog/lsu_mem.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       req_i,
    input  wire wb_pkg::inst_rec_t          rec_i,
    output logic                            valid_o,
    output logic [wb_pkg::DATA_LEN-1:0]     rdata_o
);

    import wb_pkg::*;

    logic [DATA_LEN-1:0]  mem [MEM_DEPTH];
    logic [LSU_CNT_W-1:0] cnt;

    // store lands on the request edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (req_i && rec_i.is_store) begin
            mem[rec_i.mem_addr] <= rec_i.reg_wdata;
        end
    end

    // latency counter down to the valid cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (req_i) begin
            cnt <= LSU_CNT_W'(LSU_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign valid_o = (cnt == LSU_CNT_W'(1));

    // word read in the valid cycle and ignored for stores
    assign rdata_o = valid_o ? mem[rec_i.mem_addr] : '0;

endmodule

`default_nettype wire

// File: verilog/wb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       ifu_valid_i,
    input  wire wb_pkg::inst_rec_t          rec_i,
    input  wire logic                       lsu_valid_i,
    input  wire logic [wb_pkg::DATA_LEN-1:0] lsu_rdata_i,
    output logic                            accept_o,
    output logic                            mem_req_o,
    output logic                            ready_o,
    output logic                            finish_o,
    output wb_pkg::wb_rec_t                 commit_o
);

    import wb_pkg::*;

    wb_state_t state;
    wb_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WB_WAIT_IFU;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            WB_WAIT_IFU: begin
                if (ifu_valid_i) begin
                    next_state = WB_CHECK;
                end
            end
            WB_CHECK: begin
                if (rec_i.is_mem) begin
                    next_state = WB_WAIT_MEM;
                end else begin
                    next_state = WB_COMMIT;
                end
            end
            WB_WAIT_MEM: begin
                if (lsu_valid_i) begin
                    next_state = WB_COMMIT;
                end
            end
            WB_COMMIT: begin
                next_state = WB_WAIT_IFU;
            end
            default: begin
                next_state = WB_WAIT_IFU;
            end
        endcase
    end

    assign ready_o   = (state == WB_WAIT_IFU);
    assign accept_o  = ready_o && ifu_valid_i;   // strobes while busy are dropped
    assign mem_req_o = (state == WB_CHECK) && rec_i.is_mem;

    // one cycle after the commit edge
    always_ff @(posedge clk) begin
        if (rst) begin
            finish_o <= 1'b0;
        end else begin
            finish_o <= (next_state == WB_COMMIT);
        end
    end

    // commit record is only live in the cycle before the commit edge
    always_comb begin
        commit_o = '0;
        if (next_state == WB_COMMIT) begin
            commit_o.wd        = rec_i.wd;
            commit_o.wreg      = rec_i.wreg;
            commit_o.csr_we    = rec_i.csr_we;
            commit_o.csr_wdata = rec_i.csr_wdata;
            commit_o.wdata     = rec_i.is_mem ? lsu_rdata_i : rec_i.reg_wdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int DATA_LEN    = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 1 << REG_ADDR_W;
    localparam int MEM_ADDR_W  = 6;
    localparam int MEM_DEPTH   = 1 << MEM_ADDR_W;   // 64 words

    // cycles from the request edge to the valid pulse (at least 1)
    localparam int LSU_LATENCY = 3;
    localparam int LSU_CNT_W   = $clog2(LSU_LATENCY + 1);

    // decoded instruction as handed over by execute
    typedef struct packed {
        logic                  wd;         // gpr write enable
        logic [REG_ADDR_W-1:0] wreg;
        logic                  csr_we;
        logic                  is_mem;
        logic                  is_store;   // store when set, load otherwise
        logic [MEM_ADDR_W-1:0] mem_addr;   // word address
        logic [DATA_LEN-1:0]   reg_wdata;  // alu result or store data
        logic [DATA_LEN-1:0]   csr_wdata;
    } inst_rec_t;

    // one commit into the architectural state
    typedef struct packed {
        logic                  wd;
        logic [REG_ADDR_W-1:0] wreg;
        logic                  csr_we;
        logic [DATA_LEN-1:0]   wdata;
        logic [DATA_LEN-1:0]   csr_wdata;
    } wb_rec_t;

    // writeback sequencer states
    typedef enum logic [1:0] {
        WB_WAIT_IFU  = 2'b00,   // idle and ready for issue
        WB_CHECK     = 2'b01,   // record latched and path picked
        WB_WAIT_MEM  = 2'b10,   // load/store in progress
        WB_COMMIT    = 2'b11    // write done with finish pulse
    } wb_state_t;

endpackage

`default_nettype wire

// File: verilog/wb_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_subsys_top (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          ifu_valid_i,
    input  wire wb_pkg::inst_rec_t             inst_i,
    output logic                               ready_o,
    output logic                               finish_o,
    input  wire logic [wb_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic [wb_pkg::DATA_LEN-1:0]        rd_data_o,
    output logic [wb_pkg::DATA_LEN-1:0]        csr_o
);

    import wb_pkg::*;

    logic                accept;
    logic                mem_req;
    logic                lsu_valid;
    logic [DATA_LEN-1:0] lsu_rdata;
    inst_rec_t           rec;
    wb_rec_t             commit;

    inst_latch u_latch (
        .clk    (clk),
        .rst    (rst),
        .load_i (accept),
        .inst_i (inst_i),
        .rec_o  (rec)
    );

    lsu_mem u_lsu (
        .clk     (clk),
        .rst     (rst),
        .req_i   (mem_req),
        .rec_i   (rec),
        .valid_o (lsu_valid),
        .rdata_o (lsu_rdata)
    );

    wb_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ifu_valid_i (ifu_valid_i),
        .rec_i       (rec),
        .lsu_valid_i (lsu_valid),
        .lsu_rdata_i (lsu_rdata),
        .accept_o    (accept),
        .mem_req_o   (mem_req),
        .ready_o     (ready_o),
        .finish_o    (finish_o),
        .commit_o    (commit)
    );

    arch_state u_state (
        .clk       (clk),
        .rst       (rst),
        .commit_i  (commit),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .csr_o     (csr_o)
    );

endmodule

`default_nettype wire
